// File: exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          empty,
  input  rv_pkg::word_t head_data,
  output logic          pop,
  output logic          dmem_wen,
  output rv_pkg::addr_t dmem_addr,
  output rv_pkg::word_t dmem_data
);
  import rv_pkg::*;

  // fields of the head word
  logic [6:0] opcode;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm;
  alu_op_t    op;
  logic       is_reg;
  logic       stall;

  // decode register
  logic       dec_valid;
  alu_op_t    dec_op;
  reg_idx_t   dec_rd;
  logic       dec_wr;
  word_t      dec_a;
  word_t      dec_b;

  word_t      rf [reg_count];
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      alu_y;
  logic       wb_en;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign opcode = head_data[6:0];
  assign rd     = head_data[11:7];
  assign funct3 = head_data[14:12];
  assign rs1    = head_data[19:15];
  assign rs2    = head_data[24:20];
  assign funct7 = head_data[31:25];
  assign imm    = {{(xlen-12){head_data[31]}}, head_data[31:20]};

  always_comb begin
    op     = alu_nop;
    is_reg = 1'b0;
    if (opcode == opc_op_imm) begin
      case (funct3)
        funct3_add:  op = alu_addi;
        funct3_slt:  op = alu_slti;
        funct3_sltu: op = alu_sltiu;
        funct3_xor:  op = alu_xori;
        funct3_or:   op = alu_ori;
        funct3_and:  op = alu_andi;
        funct3_sll:  op = (funct7 == funct7_base) ? alu_slli : alu_nop;
        funct3_srl: begin
          if (funct7 == funct7_base) begin
            op = alu_srli;
          end else if (funct7 == funct7_alt) begin
            op = alu_srai;
          end
        end
        default:     op = alu_nop;
      endcase
    end else if (opcode == opc_op) begin
      is_reg = 1'b1;
      if (funct7 == funct7_base) begin
        case (funct3)
          funct3_add:  op = alu_add;
          funct3_sll:  op = alu_sll;
          funct3_slt:  op = alu_slt;
          funct3_sltu: op = alu_sltu;
          funct3_xor:  op = alu_xor;
          funct3_srl:  op = alu_srl;
          funct3_or:   op = alu_or;
          funct3_and:  op = alu_and;
          default:     op = alu_nop;
        endcase
      end else if (funct7 == funct7_alt) begin
        case (funct3)
          funct3_add: op = alu_sub;
          funct3_srl: op = alu_sra;
          default:    op = alu_nop;
        endcase
      end
    end
  end

  // wait while a source matches the pending destination
  assign stall = dec_valid && dec_wr &&
                 ((rs1 == dec_rd) || (is_reg && (rs2 == dec_rd)));
  assign pop   = !empty && !stall;

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  assign wb_en = dec_valid && dec_wr;

  // x0 reads zero, a same-cycle write is passed through
  always_comb begin
    if (rs1 == '0) begin
      rs1_val = '0;
    end else if (wb_en && (rs1 == dec_rd)) begin
      rs1_val = alu_y;
    end else begin
      rs1_val = rf[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rs2_val = '0;
    end else if (wb_en && (rs2 == dec_rd)) begin
      rs2_val = alu_y;
    end else begin
      rs2_val = rf[rs2];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        rf[i] <= '0;
      end
    end else if (wb_en) begin
      rf[dec_rd] <= alu_y;
    end
  end

  ////////////////////////////////////////
  // decode register and retire
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= pop;
    end
  end

  // unknown opcodes and rd of x0 never write
  always_ff @(posedge clk) begin
    if (pop) begin
      dec_op <= op;
      dec_rd <= rd;
      dec_wr <= (op != alu_nop) && (rd != '0);
      dec_a  <= rs1_val;
      dec_b  <= is_reg ? rs2_val : imm;
    end
  end

  rv_alu rv_alu_inst (
    .op (dec_op),
    .a  (dec_a),
    .b  (dec_b),
    .y  (alu_y)
  );

  // address moves on after each retire cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dmem_wen  <= 1'b0;
      dmem_addr <= '0;
    end else begin
      dmem_wen <= dec_valid;
      if (dmem_wen) begin
        dmem_addr <= dmem_addr + insn_step;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      dmem_data <= alu_y;
    end
  end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          full,
  input  rv_pkg::word_t imem_insn,
  output rv_pkg::addr_t imem_addr,
  output logic          push,
  output rv_pkg::word_t push_data
);
  import rv_pkg::*;

  addr_t pc;
  logic  run;

  // goes high on the first edge out of reset and stays there
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // pc only moves when the word at it went into the queue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (push) begin
      pc <= pc + insn_step;
    end
  end

  assign imem_addr = pc;

  // memory answers combinationally, so the word is ready this cycle
  assign push      = run && !full;
  assign push_data = imem_insn;

endmodule

`default_nettype wire

// File: insn_queue.sv
`timescale 1ns/1ps
`default_nettype none

module insn_queue (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          push,
  input  rv_pkg::word_t push_data,
  input  logic          pop,
  output logic          full,
  output logic          empty,
  output rv_pkg::word_t head_data
);
  import rv_pkg::*;

  localparam int unsigned ptr_w = $clog2(queue_depth);
  localparam int unsigned cnt_w = $clog2(queue_depth + 1);

  localparam logic [cnt_w-1:0] count_full = cnt_w'(queue_depth);
  localparam logic [ptr_w-1:0] ptr_last   = ptr_w'(queue_depth - 1);

  word_t            mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // wrap without relying on a power of two depth
  function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
    if (ptr == ptr_last) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count == count_full);
  assign empty = (count == '0);

  // requests against a full or empty queue are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign head_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: project.f
rv_pkg.sv
rv_alu.sv
fetch_unit.sv
insn_queue.sv
exec_core.sv
rv_alu_core.sv
rv_alu_core_assertions.sv
tb_rv_alu_core.sv

// File: rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   y
);
  import rv_pkg::*;

  reg_idx_t shamt;
  logic     lt_signed;
  logic     lt_unsigned;

  // only the low five bits of b count as a shift amount
  assign shamt = b[$bits(reg_idx_t)-1:0];

  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  // immediate forms get the sign-extended immediate on b
  always_comb begin
    case (op)
      alu_addi, alu_add: begin
        y = a + b;
      end
      alu_sub: begin
        y = a - b;
      end
      alu_slti, alu_slt: begin
        y = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltiu, alu_sltu: begin
        y = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      alu_xori, alu_xor: begin
        y = a ^ b;
      end
      alu_ori, alu_or: begin
        y = a | b;
      end
      alu_andi, alu_and: begin
        y = a & b;
      end
      alu_slli, alu_sll: begin
        y = a << shamt;
      end
      alu_srli, alu_srl: begin
        y = a >> shamt;
      end
      alu_srai, alu_sra: begin
        // sign bit fills from the left
        y = word_t'($signed(a) >>> shamt);
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_core (
  input  logic          clk,
  input  logic          rst_n,
  input  rv_pkg::word_t imem_insn,
  output rv_pkg::addr_t imem_addr,
  output logic          dmem_wen,
  output rv_pkg::addr_t dmem_addr,
  output rv_pkg::word_t dmem_data
);
  import rv_pkg::*;

  // fetch to queue
  logic  push;
  word_t push_data;
  logic  full;

  // queue to execute
  logic  pop;
  logic  empty;
  word_t head_data;

  fetch_unit fetch_unit_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .full      (full),
    .imem_insn (imem_insn),
    .imem_addr (imem_addr),
    .push      (push),
    .push_data (push_data)
  );

  insn_queue insn_queue_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .full      (full),
    .empty     (empty),
    .head_data (head_data)
  );

  exec_core exec_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .empty     (empty),
    .head_data (head_data),
    .pop       (pop),
    .dmem_wen  (dmem_wen),
    .dmem_addr (dmem_addr),
    .dmem_data (dmem_data)
  );

endmodule

`default_nettype wire

// File: rv_alu_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu_core_assertions (
  input logic          clk,
  input logic          rst_n,
  input rv_pkg::addr_t imem_addr,
  input logic          dmem_wen,
  input rv_pkg::addr_t dmem_addr
);
  import rv_pkg::*;

  int unsigned fail_count = 0;

  // nothing retires on the first edge out of reset
  wen_low_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |=> !dmem_wen
  ) else begin
    $error("dmem_wen high in the first cycle after reset");
    fail_count++;
  end

  // retire slots are one word apart
  addr_steps_after_wen: assert property (
    @(posedge clk) disable iff (!rst_n)
    dmem_wen |=> (dmem_addr == $past(dmem_addr) + insn_step)
  ) else begin
    $error("dmem_addr did not step by one word after dmem_wen");
    fail_count++;
  end

  imem_holds_or_steps: assert property (
    @(posedge clk) disable iff (!rst_n)
    (imem_addr == $past(imem_addr)) || (imem_addr == $past(imem_addr) + insn_step)
  ) else begin
    $error("imem_addr moved by something other than 0 or 4");
    fail_count++;
  end

endmodule

bind rv_alu_core rv_alu_core_assertions rv_alu_core_assertions_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .imem_addr (imem_addr),
  .dmem_wen  (dmem_wen),
  .dmem_addr (dmem_addr)
);

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  localparam int unsigned xlen        = 32;
  localparam int unsigned reg_count   = 32;
  localparam int unsigned queue_depth = 4;

  typedef logic [xlen-1:0]              word_t;
  typedef logic [31:0]                  addr_t;
  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

  // byte step between instruction words and between retire slots
  localparam addr_t insn_step = 32'd4;
  localparam addr_t reset_pc  = 32'd0;

  ////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////

  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  // shared by the immediate and register forms
  localparam logic [2:0] funct3_add  = 3'h0;
  localparam logic [2:0] funct3_sll  = 3'h1;
  localparam logic [2:0] funct3_slt  = 3'h2;
  localparam logic [2:0] funct3_sltu = 3'h3;
  localparam logic [2:0] funct3_xor  = 3'h4;
  localparam logic [2:0] funct3_srl  = 3'h5;
  localparam logic [2:0] funct3_or   = 3'h6;
  localparam logic [2:0] funct3_and  = 3'h7;

  // alt selects sub, sra and srai
  localparam logic [6:0] funct7_base = 7'h00;
  localparam logic [6:0] funct7_alt  = 7'h20;

  ////////////////////////////////////////
  // alu operations
  ////////////////////////////////////////

  typedef enum logic [4:0] {
    alu_nop,
    alu_addi,
    alu_slti,
    alu_sltiu,
    alu_xori,
    alu_ori,
    alu_andi,
    alu_slli,
    alu_srli,
    alu_srai,
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

endpackage

`default_nettype wire

// File: tb_rv_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_alu_core;
  import rv_pkg::*;

  localparam int retire_timeout = 40;
  localparam int chain_len      = 8;

  logic  clk;
  logic  rst_n;
  word_t imem_insn;
  addr_t imem_addr;
  logic  dmem_wen;
  addr_t dmem_addr;
  word_t dmem_data;

  // program table with one encoded word and one expected result per row
  word_t prog_word[$];
  word_t prog_exp[$];
  word_t model_rf[reg_count];

  rv_alu_core rv_alu_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_insn (imem_insn),
    .imem_addr (imem_addr),
    .dmem_wen  (dmem_wen),
    .dmem_addr (dmem_addr),
    .dmem_data (dmem_data)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // encoding and reference model
  ////////////////////////////////////////

  function automatic logic is_reg_op(alu_op_t op);
    case (op)
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu: return 1'b1;
      alu_xor, alu_srl, alu_sra, alu_or, alu_and:   return 1'b1;
      default:                                      return 1'b0;
    endcase
  endfunction

  function automatic word_t encode(alu_op_t op, reg_idx_t rd, reg_idx_t rs1,
                                   reg_idx_t rs2, int imm);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] i12;
    f7 = funct7_base;
    case (op)
      alu_addi, alu_add, alu_sub: f3 = funct3_add;
      alu_slti, alu_slt:          f3 = funct3_slt;
      alu_sltiu, alu_sltu:        f3 = funct3_sltu;
      alu_xori, alu_xor:          f3 = funct3_xor;
      alu_ori, alu_or:            f3 = funct3_or;
      alu_andi, alu_and:          f3 = funct3_and;
      alu_slli, alu_sll:          f3 = funct3_sll;
      default:                    f3 = funct3_srl;
    endcase
    if (op == alu_sub || op == alu_sra || op == alu_srai) begin
      f7 = funct7_alt;
    end
    if (is_reg_op(op)) begin
      return {f7, rs2, rs1, f3, rd, opc_op};
    end
    i12 = imm[11:0];
    // immediate shifts carry funct7 above the 5-bit amount
    if (op == alu_slli || op == alu_srli || op == alu_srai) begin
      i12 = {f7, imm[4:0]};
    end
    return {i12, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
    logic [4:0]  sh;
    logic [63:0] ext;
    sh  = b[4:0];
    ext = {{32{a[31]}}, a};
    case (op)
      alu_addi, alu_add:   return a + b;
      alu_sub:             return a - b;
      alu_slti, alu_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltiu, alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xori, alu_xor:   return a ^ b;
      alu_ori, alu_or:     return a | b;
      alu_andi, alu_and:   return a & b;
      alu_slli, alu_sll:   return a << sh;
      alu_srli, alu_srl:   return a >> sh;
      alu_srai, alu_sra:   return word_t'(ext >> sh);
      default:             return '0;
    endcase
  endfunction

  // runs the model on the row and appends it to the table
  task automatic add_row(alu_op_t op, int rd, int rs1, int rs2, int imm);
    word_t a;
    word_t b;
    word_t y;
    a = model_rf[rs1];
    b = is_reg_op(op) ? model_rf[rs2] : word_t'(imm);
    y = model_alu(op, a, b);
    if (rd != 0) begin
      model_rf[rd] = y;
    end
    prog_word.push_back(encode(op, reg_idx_t'(rd), reg_idx_t'(rs1), reg_idx_t'(rs2), imm));
    prog_exp.push_back(y);
  endtask

  task automatic build_program();
    add_row(alu_addi,  1,  0, 0, 100);
    add_row(alu_addi,  2,  0, 0, -7);
    add_row(alu_slti,  3,  2, 0, -6);
    add_row(alu_slti,  3,  1, 0, -6);
    add_row(alu_sltiu, 4,  1, 0, -1);
    add_row(alu_sltiu, 4,  2, 0, 5);
    add_row(alu_xori,  5,  1, 0, -1);
    add_row(alu_ori,   6,  1, 0, 12'h0f0);
    add_row(alu_andi,  7,  2, 0, 12'h7f0);
    add_row(alu_slli,  8,  1, 0, 3);
    add_row(alu_srli,  9,  2, 0, 4);
    add_row(alu_srai,  10, 2, 0, 2);
    add_row(alu_add,   11, 1, 2, 0);
    add_row(alu_sub,   12, 2, 1, 0);
    // 35 wraps to a shift of 3
    add_row(alu_addi,  13, 0, 0, 35);
    add_row(alu_sll,   14, 1, 13, 0);
    add_row(alu_slt,   15, 2, 1, 0);
    add_row(alu_sltu,  16, 2, 1, 0);
    add_row(alu_xor,   17, 1, 2, 0);
    add_row(alu_srl,   18, 2, 13, 0);
    add_row(alu_sra,   19, 5, 13, 0);
    add_row(alu_or,    20, 1, 2, 0);
    add_row(alu_and,   21, 1, 2, 0);
    // x0 retires the sum but keeps reading zero
    add_row(alu_addi,  0,  1, 0, 55);
    add_row(alu_add,   22, 0, 1, 0);
    // dependent chain that stalls every pop and fills the queue
    add_row(alu_addi,  23, 0, 0, 1);
    for (int i = 0; i < chain_len; i++) begin
      add_row(alu_add, 23, 23, 23, 0);
    end
    add_row(alu_addi,  24, 23, 0, 1);
    add_row(alu_sub,   25, 24, 23, 0);
  endtask

  ////////////////////////////////////////
  // instruction memory and checks
  ////////////////////////////////////////

  function automatic word_t fetch_word(addr_t addr);
    int unsigned idx;
    idx = addr[31:2];
    if (idx < prog_word.size()) begin
      return prog_word[idx];
    end
    return encode(alu_addi, '0, '0, '0, 0);
  endfunction

  always @(negedge clk) begin
    imem_insn <= fetch_word(imem_addr);
  end

  task automatic check_word(word_t got, word_t exp, int idx);
    if (got !== exp) begin
      $display("ERROR %0t: row %0d dmem_data %h, expected %h", $time, idx, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "retired data mismatch");
    end
  endtask

  task automatic check_addr(addr_t got, addr_t exp, int idx);
    if (got !== exp) begin
      $display("ERROR %0t: row %0d dmem_addr %h, expected %h", $time, idx, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "retire address mismatch");
    end
  endtask

  task automatic wait_retire(int idx);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!dmem_wen && cycles < retire_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!dmem_wen) begin
      $display("no retirement arrived for row %0d within %0d cycles", idx, retire_timeout);
      $display("STATUS: FAIL");
      $fatal(1, "timeout waiting for dmem_wen");
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    imem_insn = '0;
    for (int i = 0; i < reg_count; i++) begin
      model_rf[i] = '0;
    end
    build_program();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < prog_word.size(); i++) begin
      wait_retire(i);
      check_word(dmem_data, prog_exp[i], i);
      check_addr(dmem_addr, addr_t'(i * 4), i);
    end
    if (rv_alu_core_inst.rv_alu_core_assertions_inst.fail_count != 0) begin
      $display("STATUS: FAIL");
      $fatal(1, "bound assertions failed");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
